// ==== common/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    // datapath widths
    localparam int op_w       = 18;   // a b d and pre-adder
    localparam int mult_w     = 36;   // product and m
    localparam int acc_w      = 48;   // c pcin x z and p
    localparam int opmode_w   = 8;
    localparam int d_concat_w = 12;   // low d bits on top of a:b in x_dab

    // opmode bit positions
    localparam int opm_x_lsb      = 0;   // bits 1:0
    localparam int opm_z_lsb      = 2;   // bits 3:2
    localparam int opm_preadd_sel = 4;   // 1 = pre-adder result into b1
    localparam int opm_cin        = 5;   // carry-in source
    localparam int opm_pre_sub    = 6;   // 1 = d - b
    localparam int opm_post_sub   = 7;   // 1 = z - (x + cin)

    // x mux select
    typedef enum logic [1:0] {
        x_zero = 2'd0,   // constant zero
        x_mult = 2'd1,   // m zero extended
        x_p    = 2'd2,   // p feedback
        x_dab  = 2'd3    // d[11:0] a b concat
    } x_sel_e;

    // z mux select
    typedef enum logic [1:0] {
        z_zero = 2'd0,   // constant zero
        z_pcin = 2'd1,   // cascade in
        z_p    = 2'd2,   // p feedback for accumulate
        z_c    = 2'd3    // registered c
    } z_sel_e;

    // register configuration
    // a and b only use the second stage register
    localparam bit a1_reg       = 1'b1;
    localparam bit b1_reg       = 1'b1;
    localparam bit c_reg        = 1'b1;
    localparam bit d_reg        = 1'b1;
    localparam bit m_reg        = 1'b1;
    localparam bit p_reg        = 1'b1;
    localparam bit opmode_reg   = 1'b1;
    localparam bit carryin_reg  = 1'b1;
    localparam bit carryout_reg = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
    parameter int width = 1   // register width in bits
) (
    input  wire logic             clk,
    input  wire logic             arst_n,   // async clear
    input  wire logic             en,       // load enable
    input  wire logic [width-1:0] d,
    output logic      [width-1:0] q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;          // all stages clear to zero
        end else if (en) begin
            q <= d;           // hold when en low
        end
    end

endmodule

`default_nettype wire

// ==== operand_path/operand_path.sv ====
`default_nettype none

module operand_path (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire logic [dsp_pkg::op_w-1:0]        a,
    input  wire logic [dsp_pkg::op_w-1:0]        b,
    input  wire logic [dsp_pkg::op_w-1:0]        d,
    input  wire logic                            cea,          // a1 enable
    input  wire logic                            ceb,          // b1 enable
    input  wire logic                            ced,          // d enable
    input  wire logic                            cem,          // m enable
    input  wire logic                            pre_sub,      // 1 = d - b
    input  wire logic                            preadd_sel,   // 0 = bypass to b
    output logic      [dsp_pkg::mult_w-1:0]      m,
    output logic      [dsp_pkg::op_w-1:0]        a_q,          // second stage a
    output logic      [dsp_pkg::op_w-1:0]        b_q,          // second stage b
    output logic      [dsp_pkg::d_concat_w-1:0]  d_low         // for x_dab
);

    logic [dsp_pkg::op_w-1:0]   d_q;       // registered d
    logic [dsp_pkg::op_w-1:0]   pre_res;   // pre-adder out
    logic [dsp_pkg::op_w-1:0]   b_sel;     // bypass mux out
    logic [dsp_pkg::mult_w-1:0] product;   // unsigned 18x18

    // d register
    if (dsp_pkg::d_reg) begin : g_dreg
        pipe_reg #(.width(dsp_pkg::op_w)) i_dreg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (ced),
            .d      (d),
            .q      (d_q)
        );
    end else begin : g_dreg_bypass
        assign d_q = d;
    end

    // pre-adder sees registered d and raw b
    always_comb begin
        if (pre_sub) begin
            pre_res = d_q - b;   // wraps mod 2^18
        end else begin
            pre_res = d_q + b;
        end
    end

    assign b_sel = preadd_sel ? pre_res : b;   // bypass mux

    // b1 stage takes the mux result
    if (dsp_pkg::b1_reg) begin : g_b1reg
        pipe_reg #(.width(dsp_pkg::op_w)) i_b1reg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (ceb),
            .d      (b_sel),
            .q      (b_q)
        );
    end else begin : g_b1reg_bypass
        assign b_q = b_sel;
    end

    // a1 stage only
    if (dsp_pkg::a1_reg) begin : g_a1reg
        pipe_reg #(.width(dsp_pkg::op_w)) i_a1reg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cea),
            .d      (a),
            .q      (a_q)
        );
    end else begin : g_a1reg_bypass
        assign a_q = a;
    end

    // full 36 bit product
    assign product = dsp_pkg::mult_w'(a_q) * dsp_pkg::mult_w'(b_q);

    if (dsp_pkg::m_reg) begin : g_mreg
        pipe_reg #(.width(dsp_pkg::mult_w)) i_mreg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cem),
            .d      (product),
            .q      (m)
        );
    end else begin : g_mreg_bypass
        assign m = product;
    end

    assign d_low = d_q[dsp_pkg::d_concat_w-1:0];   // top slice of x_dab

endmodule

`default_nettype wire

// ==== post_add_path/post_add_path.sv ====
`default_nettype none

module post_add_path (
    input  wire logic                            clk,
    input  wire logic                            arst_n,
    input  wire logic [dsp_pkg::acc_w-1:0]       c,
    input  wire logic [dsp_pkg::acc_w-1:0]       pcin,        // cascade from neighbour
    input  wire logic [dsp_pkg::mult_w-1:0]      m,
    input  wire logic [dsp_pkg::op_w-1:0]        a_q,
    input  wire logic [dsp_pkg::op_w-1:0]        b_q,
    input  wire logic [dsp_pkg::d_concat_w-1:0]  d_low,
    input  wire dsp_pkg::x_sel_e                 x_sel,
    input  wire dsp_pkg::z_sel_e                 z_sel,
    input  wire logic                            cin,         // opmode bit 5
    input  wire logic                            post_sub,    // 1 = subtract
    input  wire logic                            cec,
    input  wire logic                            cecarryin,   // cyi and cyo
    input  wire logic                            cep,
    output logic      [dsp_pkg::acc_w-1:0]       p,
    output logic                                 carryout
);

    logic [dsp_pkg::acc_w-1:0] c_q;        // registered c
    logic                      cin_q;      // registered carry-in
    logic [dsp_pkg::acc_w-1:0] x_mux;
    logic [dsp_pkg::acc_w-1:0] z_mux;
    logic [dsp_pkg::acc_w:0]   x_plus_c;   // x + cin with room for 2^48
    logic [dsp_pkg::acc_w:0]   post_res;   // bit 48 is carry or borrow

    // c register
    if (dsp_pkg::c_reg) begin : g_creg
        pipe_reg #(.width(dsp_pkg::acc_w)) i_creg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cec),
            .d      (c),
            .q      (c_q)
        );
    end else begin : g_creg_bypass
        assign c_q = c;
    end

    // carry-in register
    if (dsp_pkg::carryin_reg) begin : g_cyi
        pipe_reg #(.width(1)) i_cyi (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cecarryin),
            .d      (cin),
            .q      (cin_q)
        );
    end else begin : g_cyi_bypass
        assign cin_q = cin;
    end

    // x mux
    always_comb begin
        case (x_sel)
            dsp_pkg::x_zero: x_mux = '0;
            dsp_pkg::x_mult: x_mux = {{(dsp_pkg::acc_w - dsp_pkg::mult_w){1'b0}}, m};
            dsp_pkg::x_p:    x_mux = p;                     // feedback
            dsp_pkg::x_dab:  x_mux = {d_low, a_q, b_q};     // 12 + 18 + 18
            default:         x_mux = '0;
        endcase
    end

    // z mux
    always_comb begin
        case (z_sel)
            dsp_pkg::z_zero: z_mux = '0;
            dsp_pkg::z_pcin: z_mux = pcin;
            dsp_pkg::z_p:    z_mux = p;    // accumulate path
            dsp_pkg::z_c:    z_mux = c_q;
            default:         z_mux = '0;
        endcase
    end

    // carry folded into x before add or sub
    assign x_plus_c = {1'b0, x_mux} + {{dsp_pkg::acc_w{1'b0}}, cin_q};

    always_comb begin
        if (post_sub) begin
            post_res = {1'b0, z_mux} - x_plus_c;   // msb set on borrow
        end else begin
            post_res = {1'b0, z_mux} + x_plus_c;   // msb set on carry
        end
    end

    // p register
    if (dsp_pkg::p_reg) begin : g_preg
        pipe_reg #(.width(dsp_pkg::acc_w)) i_preg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cep),
            .d      (post_res[dsp_pkg::acc_w-1:0]),
            .q      (p)
        );
    end else begin : g_preg_bypass
        assign p = post_res[dsp_pkg::acc_w-1:0];
    end

    // carry-out register shares the carry-in enable
    if (dsp_pkg::carryout_reg) begin : g_cyo
        pipe_reg #(.width(1)) i_cyo (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (cecarryin),
            .d      (post_res[dsp_pkg::acc_w]),
            .q      (carryout)
        );
    end else begin : g_cyo_bypass
        assign carryout = post_res[dsp_pkg::acc_w];
    end

endmodule

`default_nettype wire

// ==== hdl/dsp_slice.sv ====
`default_nettype none

module dsp_slice (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic [dsp_pkg::op_w-1:0]      a,
    input  wire logic [dsp_pkg::op_w-1:0]      b,
    input  wire logic [dsp_pkg::op_w-1:0]      d,
    input  wire logic [dsp_pkg::acc_w-1:0]     c,
    input  wire logic [dsp_pkg::acc_w-1:0]     pcin,
    input  wire logic [dsp_pkg::opmode_w-1:0]  opmode,
    input  wire logic                          cea,
    input  wire logic                          ceb,
    input  wire logic                          cec,
    input  wire logic                          ced,
    input  wire logic                          cem,
    input  wire logic                          cep,
    input  wire logic                          ceopmode,
    input  wire logic                          cecarryin,
    output logic      [dsp_pkg::mult_w-1:0]    m,
    output logic      [dsp_pkg::acc_w-1:0]     p,
    output logic                               carryout
);

    logic [dsp_pkg::opmode_w-1:0]   opmode_q;   // registered opmode
    logic [dsp_pkg::op_w-1:0]       a_q;        // second stage a
    logic [dsp_pkg::op_w-1:0]       b_q;        // second stage b
    logic [dsp_pkg::d_concat_w-1:0] d_low;
    dsp_pkg::x_sel_e                x_sel;
    dsp_pkg::z_sel_e                z_sel;

    // opmode register
    if (dsp_pkg::opmode_reg) begin : g_opmode_reg
        pipe_reg #(.width(dsp_pkg::opmode_w)) i_opmode_reg (
            .clk    (clk),
            .arst_n (arst_n),
            .en     (ceopmode),
            .d      (opmode),
            .q      (opmode_q)
        );
    end else begin : g_opmode_bypass
        assign opmode_q = opmode;
    end

    // mux selects out of the opmode word
    assign x_sel = dsp_pkg::x_sel_e'(opmode_q[dsp_pkg::opm_x_lsb +: 2]);
    assign z_sel = dsp_pkg::z_sel_e'(opmode_q[dsp_pkg::opm_z_lsb +: 2]);

    operand_path i_operand_path (
        .clk        (clk),
        .arst_n     (arst_n),
        .a          (a),
        .b          (b),
        .d          (d),
        .cea        (cea),
        .ceb        (ceb),
        .ced        (ced),
        .cem        (cem),
        .pre_sub    (opmode_q[dsp_pkg::opm_pre_sub]),
        .preadd_sel (opmode_q[dsp_pkg::opm_preadd_sel]),
        .m          (m),          // also feeds x mux
        .a_q        (a_q),
        .b_q        (b_q),
        .d_low      (d_low)
    );

    post_add_path i_post_add_path (
        .clk       (clk),
        .arst_n    (arst_n),
        .c         (c),
        .pcin      (pcin),
        .m         (m),
        .a_q       (a_q),
        .b_q       (b_q),
        .d_low     (d_low),
        .x_sel     (x_sel),
        .z_sel     (z_sel),
        .cin       (opmode_q[dsp_pkg::opm_cin]),        // no external carry pin
        .post_sub  (opmode_q[dsp_pkg::opm_post_sub]),
        .cec       (cec),
        .cecarryin (cecarryin),
        .cep       (cep),
        .p         (p),
        .carryout  (carryout)
    );

endmodule

`default_nettype wire

// ==== dv/dsp_vectors.svh ====
`ifndef DSP_VECTORS_SVH
`define DSP_VECTORS_SVH

localparam int num_rows = 18;

// row columns are a b c d pcin opmode en_mask cep_pulses exp_m exp_p exp_carryout
// en_mask bits from 7 down to 0 are cecarryin ceopmode cep cem ced cec ceb cea
vec_t vectors [num_rows];

task automatic load_vectors();
    // plain multiply, x_mult z_zero
    vectors[0]  = '{18'h00003, 18'h00005, 48'h000000000000, 18'h00000, 48'h000000000000,
                    8'h01, 8'hFF, 8'd0, 36'h00000000F, 48'h00000000000F, 1'b0};
    // pre-adder d + b
    vectors[1]  = '{18'h00002, 18'h00010, 48'h000000000000, 18'h00100, 48'h000000000000,
                    8'h11, 8'hFF, 8'd0, 36'h000000220, 48'h000000000220, 1'b0};
    // pre-subtract d - b
    vectors[2]  = '{18'h00003, 18'h00020, 48'h000000000000, 18'h00100, 48'h000000000000,
                    8'h51, 8'hFF, 8'd0, 36'h0000002A0, 48'h0000000002A0, 1'b0};
    // d - b wraps at 18 bits
    vectors[3]  = '{18'h00001, 18'h00005, 48'h000000000000, 18'h00002, 48'h000000000000,
                    8'h51, 8'hFF, 8'd0, 36'h00003FFFD, 48'h00000003FFFD, 1'b0};
    // largest unsigned product
    vectors[4]  = '{18'h3FFFF, 18'h3FFFF, 48'h000000000000, 18'h00000, 48'h000000000000,
                    8'h01, 8'hFF, 8'd0, 36'hFFFF80001, 48'h000FFFF80001, 1'b0};
    // c + m + cin
    vectors[5]  = '{18'h00004, 18'h00006, 48'h000000001000, 18'h00000, 48'h000000000000,
                    8'h2D, 8'hFF, 8'd0, 36'h000000018, 48'h000000001019, 1'b0};
    // pcin passes with x_zero
    vectors[6]  = '{18'h00004, 18'h00006, 48'h000000001000, 18'h00000, 48'h123456789ABC,
                    8'h04, 8'hFF, 8'd0, 36'h000000018, 48'h123456789ABC, 1'b0};
    // d a b concat on x
    vectors[7]  = '{18'h00005, 18'h00007, 48'h000000001000, 18'h12ABC, 48'h123456789ABC,
                    8'h03, 8'hFF, 8'd0, 36'h000000023, 48'hABC000140007, 1'b0};
    // all ones concat plus pcin overflows
    vectors[8]  = '{18'h3FFFF, 18'h3FFFF, 48'h000000000000, 18'h3FFFF, 48'h000000000001,
                    8'h07, 8'hFF, 8'd0, 36'hFFFF80001, 48'h000000000000, 1'b1};
    // c - (m + cin) borrows
    vectors[9]  = '{18'h00002, 18'h00003, 48'h000000000005, 18'h00000, 48'h000000000000,
                    8'hAD, 8'hFF, 8'd0, 36'h000000006, 48'hFFFFFFFFFFFE, 1'b1};
    // c - m without borrow
    vectors[10] = '{18'h00002, 18'h00003, 48'h000000000100, 18'h00000, 48'h000000000000,
                    8'h8D, 8'hFF, 8'd0, 36'h000000006, 48'h0000000000FA, 1'b0};
    // x_p with cin counts up per pulse
    vectors[11] = '{18'h00002, 18'h00003, 48'h000000000100, 18'h00000, 48'h000000000000,
                    8'h22, 8'hFF, 8'd3, 36'h000000006, 48'h0000000000FD, 1'b0};
    // load p = c + m
    vectors[12] = '{18'h00100, 18'h00010, 48'h000000005000, 18'h00000, 48'h000000000000,
                    8'h0D, 8'hFF, 8'd0, 36'h000001000, 48'h000000006000, 1'b0};
    // accumulate m + 1 five times
    vectors[13] = '{18'h00100, 18'h00010, 48'h000000005000, 18'h00000, 48'h000000000000,
                    8'h29, 8'hFF, 8'd5, 36'h000001000, 48'h00000000B005, 1'b0};
    // load near the top of the range
    vectors[14] = '{18'h00010, 18'h00010, 48'hFFFFFFFFF000, 18'h00000, 48'h000000000000,
                    8'h0D, 8'hFF, 8'd0, 36'h000000100, 48'hFFFFFFFFF100, 1'b0};
    // accumulate 14 times, next add would carry
    vectors[15] = '{18'h00010, 18'h00010, 48'hFFFFFFFFF000, 18'h00000, 48'h000000000000,
                    8'h09, 8'hFF, 8'd14, 36'h000000100, 48'hFFFFFFFFFF00, 1'b1};
    // cea low so the new a is ignored
    vectors[16] = '{18'h00999, 18'h00010, 48'hFFFFFFFFF000, 18'h00000, 48'h000000000000,
                    8'h01, 8'hFE, 8'd0, 36'h000000100, 48'h000000000100, 1'b0};
    // cep and cecarryin low so p and carryout hold, c + m would carry
    vectors[17] = '{18'h00020, 18'h00010, 48'hFFFFFFFFFFFF, 18'h00000, 48'h000000000000,
                    8'h0D, 8'h5F, 8'd0, 36'h000000200, 48'h000000000100, 1'b0};
endtask

`endif

// ==== dv/dsp_slice_tb.sv ====
`default_nettype none

module dsp_slice_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period    = 4;    // 8 ns clock
    localparam int num_random     = 8;    // random multiply rows
    localparam int cycles_per_row = 16;

    typedef struct packed {
        logic [dsp_pkg::op_w-1:0]     a;
        logic [dsp_pkg::op_w-1:0]     b;
        logic [dsp_pkg::acc_w-1:0]    c;
        logic [dsp_pkg::op_w-1:0]     d;
        logic [dsp_pkg::acc_w-1:0]    pcin;
        logic [dsp_pkg::opmode_w-1:0] opmode;
        logic [7:0]                   en_mask;   // cecarryin down to cea
        logic [7:0]                   pulses;    // cep pulses after settling
        logic [dsp_pkg::mult_w-1:0]   exp_m;
        logic [dsp_pkg::acc_w-1:0]    exp_p;
        logic                         exp_co;
    } vec_t;

    `include "dsp_vectors.svh"

    localparam int timeout_ns = (num_rows + num_random) * cycles_per_row * 2 * half_period * 2;

    logic                          clk;
    logic                          arst_n;
    logic [dsp_pkg::op_w-1:0]      a;
    logic [dsp_pkg::op_w-1:0]      b;
    logic [dsp_pkg::op_w-1:0]      d;
    logic [dsp_pkg::acc_w-1:0]     c;
    logic [dsp_pkg::acc_w-1:0]     pcin;
    logic [dsp_pkg::opmode_w-1:0]  opmode;
    logic                          cea;
    logic                          ceb;
    logic                          cec;
    logic                          ced;
    logic                          cem;
    logic                          cep;
    logic                          ceopmode;
    logic                          cecarryin;
    logic [dsp_pkg::mult_w-1:0]    m;
    logic [dsp_pkg::acc_w-1:0]     p;
    logic                          carryout;

    int     errors;
    int     checks;
    integer seed;

    dsp_slice i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .a         (a),
        .b         (b),
        .d         (d),
        .c         (c),
        .pcin      (pcin),
        .opmode    (opmode),
        .cea       (cea),
        .ceb       (ceb),
        .cec       (cec),
        .ced       (ced),
        .cem       (cem),
        .cep       (cep),
        .ceopmode  (ceopmode),
        .cecarryin (cecarryin),
        .m         (m),
        .p         (p),
        .carryout  (carryout)
    );

    always #(half_period) clk = ~clk;

    task automatic check_value(input string name, input logic [dsp_pkg::acc_w-1:0] expected,
                               input logic [dsp_pkg::acc_w-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
        end
    endtask

    // reference product built from partial products
    function automatic logic [dsp_pkg::mult_w-1:0] shift_add_product(
            input logic [dsp_pkg::op_w-1:0] x, input logic [dsp_pkg::op_w-1:0] y);
        logic [dsp_pkg::mult_w-1:0] acc;
        acc = '0;
        for (int i = 0; i < dsp_pkg::op_w; i++) begin
            if (y[i]) begin
                acc = acc + (dsp_pkg::mult_w'(x) << i);   // one row per set bit
            end
        end
        return acc;
    endfunction

    task automatic drive_row(input vec_t v);
        a         <= v.a;
        b         <= v.b;
        c         <= v.c;
        d         <= v.d;
        pcin      <= v.pcin;
        opmode    <= v.opmode;
        cea       <= v.en_mask[0];
        ceb       <= v.en_mask[1];
        cec       <= v.en_mask[2];
        ced       <= v.en_mask[3];
        cem       <= v.en_mask[4];
        cep       <= (v.pulses == 8'd0) ? v.en_mask[5] : 1'b0;   // held off until pulses
        ceopmode  <= v.en_mask[6];
        cecarryin <= v.en_mask[7];
    endtask

    task automatic run_row(input vec_t v);
        @(posedge clk);
        drive_row(v);
        repeat (6) @(posedge clk);      // pipeline settles
        if (v.pulses != 8'd0) begin
            cep <= 1'b1;
            repeat (v.pulses) @(posedge clk);
            cep <= 1'b0;                // exactly pulses edges with cep high
        end
        repeat (4) @(posedge clk);
        @(negedge clk);                 // sample away from the active edge
    endtask

    task automatic check_row(input vec_t v, input int idx);
        check_value($sformatf("m row %0d", idx), dsp_pkg::acc_w'(v.exp_m), dsp_pkg::acc_w'(m));
        check_value($sformatf("p row %0d", idx), v.exp_p, p);
        check_value($sformatf("carryout row %0d", idx), dsp_pkg::acc_w'(v.exp_co),
                    dsp_pkg::acc_w'(carryout));
    endtask

    initial begin
        #(timeout_ns);
        $display("timeout after %0d ns with rows still running", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        vec_t rv;
        int   rnd;
        clk       = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 71;
        arst_n    <= 1'b0;
        a         <= '0;
        b         <= '0;
        d         <= '0;
        c         <= '0;
        pcin      <= '0;
        opmode    <= '0;
        cea       <= 1'b0;
        ceb       <= 1'b0;
        cec       <= 1'b0;
        ced       <= 1'b0;
        cem       <= 1'b0;
        cep       <= 1'b0;
        ceopmode  <= 1'b0;
        cecarryin <= 1'b0;
        load_vectors();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("m after reset", '0, dsp_pkg::acc_w'(m));
        check_value("p after reset", '0, p);
        check_value("carryout after reset", '0, dsp_pkg::acc_w'(carryout));

        for (int i = 0; i < num_rows; i++) begin
            run_row(vectors[i]);
            check_row(vectors[i], i);
        end

        for (int i = 0; i < num_random; i++) begin
            rnd        = $random(seed);
            rv.a       = rnd[dsp_pkg::op_w-1:0];
            rnd        = $random(seed);
            rv.b       = rnd[dsp_pkg::op_w-1:0];
            rv.c       = '0;
            rv.d       = '0;
            rv.pcin    = '0;
            rv.opmode  = 8'h01;             // x_mult z_zero add, no pre-adder
            rv.en_mask = 8'hFF;
            rv.pulses  = 8'd0;
            rv.exp_m   = shift_add_product(rv.a, rv.b);
            rv.exp_p   = dsp_pkg::acc_w'(rv.exp_m);
            rv.exp_co  = 1'b0;
            run_row(rv);
            check_row(rv, num_rows + i);
        end

        $display("summary %0d checks %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+dv
common/dsp_pkg.sv
hdl/pipe_reg.sv
operand_path/operand_path.sv
post_add_path/post_add_path.sv
hdl/dsp_slice.sv
dv/dsp_slice_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the dsp slice testbench with verilator and run it
# exit status is nonzero unless the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module dsp_slice_tb \
    -f sources.f \
    -o dsp_slice_sim \
    && ./obj_dir/dsp_slice_sim \
    | tee /dev/stderr \
    | grep -xF "Simulation completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

exit 0
